// File: pifo_pkg.sv
package pifo_pkg;

    // --------------------------------------------------
    // Widths and tree geometry
    // --------------------------------------------------
    localparam int VALUE_W    = 16;
    localparam int COUNT_W    = 10;
    localparam int FANOUT     = 4;
    localparam int SLOT_W     = 2;
    localparam int NUM_LEVELS = 3;
    localparam int ADDR_W     = SLOT_W * NUM_LEVELS; // Link address, wide enough for any level

    // Root command spacing in cycles
    localparam int PUSH_GAP = 2;
    localparam int POP_GAP  = 3;
    localparam int GAP_W    = $clog2(POP_GAP + 1);

    // --------------------------------------------------
    // Data types
    // --------------------------------------------------
    typedef logic [VALUE_W-1:0] value_t;
    typedef logic [COUNT_W-1:0] count_t;

    typedef struct packed {
        count_t count; // Items held in this slot and below it
        value_t value;
    } slot_t;

    typedef slot_t [FANOUT-1:0] node_t; // One memory word

    localparam value_t EMPTY_VALUE = '1; // Marks a free slot, also the empty-queue pop result
    localparam slot_t  EMPTY_SLOT  = '{count: '0, value: EMPTY_VALUE};

    typedef enum logic {
        OP_PUSH = 1'b0,
        OP_POP  = 1'b1
    } op_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_PUSH = 2'b01,
        ST_POP  = 2'b11,
        ST_WB   = 2'b10
    } level_state_e;

endpackage

// File: pifo_link_if.sv
`timescale 1ns/1ps

// Commands from one tree level to the level below it
interface pifo_link_if;
    import pifo_pkg::*;

    logic              push;       // One-cycle pulse
    value_t            push_data;
    logic              pop;        // One-cycle pulse, never with push
    logic [ADDR_W-1:0] child_addr; // Parent address * FANOUT + slot
    value_t            pop_data;   // Valid the cycle after pop

    modport parent (
        output push, push_data, pop, child_addr,
        input  pop_data
    );

    modport child (
        input  push, push_data, pop, child_addr,
        output pop_data
    );

endinterface

// File: pifo_node_ram.sv
`timescale 1ns/1ps

module pifo_node_ram #(
    parameter  int DEPTH = 1,
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic            i_clk,
    input  logic            i_arst_n,
    input  logic            i_rd_en,
    input  logic [AW-1:0]   i_rd_addr,
    input  logic            i_wr_en,
    input  logic [AW-1:0]   i_wr_addr,
    input  pifo_pkg::node_t i_wr_data,
    output pifo_pkg::node_t o_rd_data
);
    import pifo_pkg::*;

    node_t mem [DEPTH];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int w = 0; w < DEPTH; w++) begin
                mem[w] <= {FANOUT{EMPTY_SLOT}}; // Whole tree starts empty
            end
            o_rd_data <= {FANOUT{EMPTY_SLOT}};
        end else begin
            if (i_wr_en) mem[i_wr_addr] <= i_wr_data;
            if (i_rd_en) o_rd_data <= mem[i_rd_addr]; // Held until the next read
        end
    end

    // Root spacing keeps every node update clear of the next read
    a_no_rd_wr_collision: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_rd_en && i_wr_en && (i_rd_addr == i_wr_addr)));

endmodule

// File: pifo_level.sv
`timescale 1ns/1ps

module pifo_level #(
    parameter int LEVEL = 0
) (
    input  logic        i_clk,
    input  logic        i_arst_n,
    pifo_link_if.child  up,
    pifo_link_if.parent down
);
    import pifo_pkg::*;

    localparam int DEPTH   = FANOUT ** LEVEL;
    localparam int AW      = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam bit IS_LAST = (LEVEL == NUM_LEVELS - 1);

    level_state_e      state;
    logic [ADDR_W-1:0] addr_q;      // Node being worked on
    value_t            push_q;      // Value arriving from above
    node_t             rd_node;
    node_t             wr_node;
    logic              wr_en;
    logic [SLOT_W-1:0] cnt_sel;     // Least loaded slot
    logic [SLOT_W-1:0] val_sel;     // Slot holding the minimum
    logic [SLOT_W-1:0] dn_slot;
    slot_t             push_slot;
    slot_t             pop_slot;
    logic              child_push;
    value_t            child_value;
    value_t            refill;

    // --------------------------------------------------
    // Node memory
    // --------------------------------------------------
    pifo_node_ram #(
        .DEPTH (DEPTH)
    ) u_node_ram (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_rd_en   (up.push | up.pop),
        .i_rd_addr (up.child_addr[AW-1:0]),
        .i_wr_en   (wr_en),
        .i_wr_addr (addr_q[AW-1:0]),
        .i_wr_data (wr_node),
        .o_rd_data (rd_node)
    );

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= ST_IDLE;
        end else if (up.push) begin
            state <= ST_PUSH;
        end else if (up.pop) begin
            state <= ST_POP;
        end else if (state == ST_POP) begin
            state <= ST_WB; // Child result arrives here
        end else begin
            state <= ST_IDLE;
        end
    end

    always_ff @(posedge i_clk) begin
        if (up.push || up.pop) begin
            addr_q <= up.child_addr;
            push_q <= up.push_data;
        end
    end

    // --------------------------------------------------
    // Slot selection, lowest index wins ties
    // --------------------------------------------------
    always_comb begin
        cnt_sel = '0;
        val_sel = '0;
        for (int i = 1; i < FANOUT; i++) begin
            if (rd_node[i].count < rd_node[cnt_sel].count) cnt_sel = SLOT_W'(i);
            if (rd_node[i].value < rd_node[val_sel].value) val_sel = SLOT_W'(i);
        end
    end

    assign push_slot = rd_node[cnt_sel];
    assign pop_slot  = rd_node[val_sel];

    if (IS_LAST) begin : g_leaf
        assign refill = EMPTY_VALUE; // Nothing below the leaves
    end else begin : g_inner
        assign refill = down.pop_data;
    end

    // Node update for the write cycle
    always_comb begin
        wr_node     = rd_node;
        child_push  = 1'b0;
        child_value = push_q;
        case (state)
            ST_PUSH: begin
                wr_node[cnt_sel].count = push_slot.count + 1'b1;
                if (push_slot.value == EMPTY_VALUE) begin
                    wr_node[cnt_sel].value = push_q;
                end else if (push_q < push_slot.value) begin
                    wr_node[cnt_sel].value = push_q; // Larger stored value moves down
                    child_push             = 1'b1;
                    child_value            = push_slot.value;
                end else begin
                    child_push = 1'b1; // Incoming goes down, also on a tie
                end
            end
            ST_WB: begin
                if (pop_slot.count != '0) begin
                    wr_node[val_sel].count = pop_slot.count - 1'b1;
                    wr_node[val_sel].value = refill;
                end
            end
            default: ;
        endcase
    end

    assign wr_en = (state == ST_PUSH) || (state == ST_WB);

    // --------------------------------------------------
    // Link outputs
    // --------------------------------------------------
    assign up.pop_data = pop_slot.value; // Read by the parent in its ST_WB

    assign dn_slot         = (state == ST_PUSH) ? cnt_sel : val_sel;
    assign down.push       = !IS_LAST && (state == ST_PUSH) && child_push;
    assign down.push_data  = child_value;
    assign down.pop        = !IS_LAST && (state == ST_POP) && (pop_slot.count != '0);
    assign down.child_addr = {addr_q[ADDR_W-SLOT_W-1:0], dn_slot};

    a_up_one_cmd: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(up.push && up.pop));

    // The parent must leave room for the write-back
    a_no_cmd_in_pop: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (state == ST_POP) |-> !(up.push || up.pop));

endmodule

// File: pifo_ingress.sv
`timescale 1ns/1ps

module pifo_ingress (
    input  logic             i_clk,
    input  logic             i_arst_n,
    input  logic             i_req,
    input  pifo_pkg::op_e    i_op,
    input  pifo_pkg::value_t i_data,
    pifo_link_if.parent      root,
    output logic             o_push_done,
    output logic             o_pop_pending
);
    import pifo_pkg::*;

    typedef enum logic {
        IG_IDLE,
        IG_BUSY
    } ingress_state_e;

    ingress_state_e   state;
    logic [GAP_W-1:0] cool;     // Cycles left before the next root command
    logic             push_r;
    logic             pop_r;
    logic             pop_pend_r;
    value_t           data_q;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state      <= IG_IDLE;
            cool       <= '0;
            push_r     <= 1'b0;
            pop_r      <= 1'b0;
            pop_pend_r <= 1'b0;
        end else begin
            push_r     <= 1'b0;
            pop_r      <= 1'b0;
            pop_pend_r <= pop_r; // Root result valid one cycle after the pulse
            if (cool != '0) cool <= cool - 1'b1;
            case (state)
                IG_IDLE: begin
                    if (i_req && (cool == '0)) begin
                        push_r <= (i_op == OP_PUSH);
                        pop_r  <= (i_op == OP_POP);
                        cool   <= (i_op == OP_POP) ? GAP_W'(POP_GAP - 1) : GAP_W'(PUSH_GAP - 1);
                        state  <= IG_BUSY;
                    end
                end
                IG_BUSY: if (!i_req) state <= IG_IDLE; // One command per request
                default: state <= IG_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if ((state == IG_IDLE) && i_req) data_q <= i_data;
    end

    assign root.push       = push_r;
    assign root.push_data  = data_q;
    assign root.pop        = pop_r;
    assign root.child_addr = '0; // Single root node
    assign o_push_done     = push_r;
    assign o_pop_pending   = pop_pend_r;

endmodule

// File: pifo_egress.sv
`timescale 1ns/1ps

module pifo_egress (
    input  logic             i_clk,
    input  logic             i_arst_n,
    input  logic             i_req,
    input  logic             i_push_done,
    input  logic             i_pop_pending,
    input  pifo_pkg::value_t i_pop_data,
    output logic             o_ack,
    output pifo_pkg::value_t o_data
);
    import pifo_pkg::*;

    value_t data_q;

    // Ack phase of the host handshake
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ack <= 1'b0;
        end else if (i_push_done || i_pop_pending) begin
            o_ack <= 1'b1;
        end else if (!i_req) begin
            o_ack <= 1'b0; // Host has released the request
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_pop_pending) data_q <= i_pop_data; // Root minimum
    end

    assign o_data = data_q;

    a_ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $rose(o_ack) |-> $past(i_req));

endmodule

// File: pifo_top.sv
`timescale 1ns/1ps

module pifo_top (
    input  logic             i_clk,
    input  logic             i_arst_n,
    input  logic             i_req,
    input  pifo_pkg::op_e    i_op,
    input  pifo_pkg::value_t i_data,
    output logic             o_ack,
    output pifo_pkg::value_t o_data
);
    import pifo_pkg::*;

    logic push_done;
    logic pop_pending;

    // Entry g feeds level g, the last one hangs below the leaves
    pifo_link_if link [NUM_LEVELS+1] ();

    // --------------------------------------------------
    // Host request side
    // --------------------------------------------------
    pifo_ingress u_ingress (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_req         (i_req),
        .i_op          (i_op),
        .i_data        (i_data),
        .root          (link[0]),
        .o_push_done   (push_done),
        .o_pop_pending (pop_pending)
    );

    // --------------------------------------------------
    // Tree levels
    // --------------------------------------------------
    for (genvar g = 0; g < NUM_LEVELS; g++) begin : g_level
        pifo_level #(
            .LEVEL (g)
        ) u_level (
            .i_clk    (i_clk),
            .i_arst_n (i_arst_n),
            .up       (link[g]),
            .down     (link[g+1])
        );
    end

    // Host response side
    pifo_egress u_egress (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_req         (i_req),
        .i_push_done   (push_done),
        .i_pop_pending (pop_pending),
        .i_pop_data    (link[0].pop_data),
        .o_ack         (o_ack),
        .o_data        (o_data)
    );

endmodule

// File: tb_pifo.sv
`timescale 1ns/1ps

module tb_pifo;
    import pifo_pkg::*;

    localparam int PLANNED_OPS = 1 + 9 + 60 + 16 + 80; // Handshakes over all tests
    localparam int MIXED_OPS   = 80;
    localparam int MAX_HELD    = 40;

    logic   i_clk;
    logic   i_arst_n;
    logic   i_req;
    op_e    i_op;
    value_t i_data;
    logic   o_ack;
    value_t o_data;

    value_t      model_q [$]; // Kept in ascending order
    logic [31:0] lcg_state = 32'h23e9;
    int          errors    = 0;
    int          tests     = 0;
    logic        ack_q     = 1'b0;
    logic        req_q     = 1'b0;

    pifo_top u_dut (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_req    (i_req),
        .i_op     (i_op),
        .i_data   (i_data),
        .o_ack    (o_ack),
        .o_data   (o_data)
    );

    initial i_clk = 1'b0;
    always #20 i_clk = ~i_clk;

    // --------------------------------------------------
    // Reference model and stimulus helpers
    // --------------------------------------------------
    function automatic value_t next_value();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return value_t'(lcg_state[31:16] % 16'hffff); // Never the empty marker
    endfunction

    task automatic model_insert(input value_t v);
        int i;
        i = 0;
        while (i < model_q.size() && model_q[i] <= v) i++;
        model_q.insert(i, v);
    endtask

    function automatic value_t model_take_min();
        if (model_q.size() == 0) return EMPTY_VALUE;
        return model_q.pop_front();
    endfunction

    task automatic compare_value(input string name, input value_t exp, input value_t act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_ack(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    // Four-phase handshake entered and left 5 ns after a rising edge
    task automatic handshake(input op_e op, input value_t data, output value_t result);
        i_op   = op;
        i_data = data;
        i_req  = 1'b1;
        while (!o_ack) begin
            @(posedge i_clk);
            #5;
        end
        result = o_data;
        i_req  = 1'b0;
        while (o_ack) begin
            @(posedge i_clk);
            #5;
        end
    endtask

    task automatic do_push(input value_t v);
        value_t unused;
        handshake(OP_PUSH, v, unused);
        model_insert(v);
    endtask

    task automatic do_pop(input string name, output value_t got);
        handshake(OP_POP, '0, got);
        compare_value(name, model_take_min(), got);
    endtask

    task automatic report_test(input string name, input int err_start);
        tests++;
        if (errors == err_start) $display("[%0d] %s: ok", tests, name);
        else $display("[%0d] %s: %0d errors", tests, name, errors - err_start);
    endtask

    // Handshake order checked at each falling edge against the previous one
    always @(negedge i_clk) begin
        if (i_arst_n) begin
            if (o_ack && !ack_q && !req_q) begin
                $display("o_ack rose while i_req was low at %0t", $time);
                errors++;
            end
            if (!o_ack && ack_q && req_q) begin
                $display("o_ack fell before i_req was released at %0t", $time);
                errors++;
            end
        end
        ack_q = o_ack;
        req_q = i_req;
    end

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic check_reset_empty();
        int     e0;
        value_t got;
        e0 = errors;
        compare_ack("reset_empty", 1'b0, o_ack);
        do_pop("reset_empty", got);
        report_test("reset_empty", e0);
    endtask

    task automatic pop_in_order();
        int     e0;
        value_t got;
        e0 = errors;
        do_push(16'h0040);
        do_push(16'h0011);
        do_push(16'h0900);
        do_push(16'h0023);
        for (int i = 0; i < 5; i++) do_pop("pop_in_order", got); // Fifth one is empty
        report_test("pop_in_order", e0);
    endtask

    task automatic fill_and_drain();
        int     e0;
        value_t got;
        e0 = errors;
        for (int i = 0; i < 30; i++) do_push(next_value()); // Reaches level 2
        for (int i = 0; i < 30; i++) do_pop("fill_and_drain", got);
        report_test("fill_and_drain", e0);
    endtask

    task automatic duplicates_kept();
        int     e0;
        value_t got;
        value_t prev;
        e0   = errors;
        prev = '0;
        do_push(16'd7);
        do_push(16'd3);
        do_push(16'd7);
        do_push(16'd100);
        do_push(16'd3);
        do_push(16'd3);
        do_push(16'd50);
        do_push(16'd7);
        for (int i = 0; i < 8; i++) begin
            do_pop("duplicates_kept", got);
            if (got < prev) begin
                $display("duplicates_kept: pop order went down from %h to %h", prev, got);
                errors++;
            end
            prev = got;
        end
        report_test("duplicates_kept", e0);
    endtask

    task automatic mixed_traffic();
        int     e0;
        value_t v;
        value_t got;
        e0 = errors;
        for (int n = 0; n < MIXED_OPS; n++) begin
            v = next_value();
            if (v[0] && model_q.size() < MAX_HELD) do_push(v);
            else do_pop("mixed_traffic", got);
        end
        report_test("mixed_traffic", e0);
    endtask

    // --------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------
    initial begin
        i_arst_n = 1'b0;
        i_req    = 1'b0;
        i_op     = OP_PUSH;
        i_data   = '0;
        repeat (2) @(posedge i_clk);
        #5;
        i_arst_n = 1'b1;
        check_reset_empty();
        pop_in_order();
        fill_and_drain();
        duplicates_kept();
        mixed_traffic();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        repeat (PLANNED_OPS * 20) @(posedge i_clk);
        $display("Timeout, the DUT stopped answering requests");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: compile.f
pifo_pkg.sv
pifo_link_if.sv
pifo_node_ram.sv
pifo_level.sv
pifo_ingress.sv
pifo_egress.sv
pifo_top.sv
tb_pifo.sv

// File: Makefile
SRCS := $(shell cat compile.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_pifo: compile.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_pifo -f compile.f

run: obj_dir/Vtb_pifo
	@out=$$(./obj_dir/Vtb_pifo); echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
